// ==== hdl/conv_pkg.sv ====
package conv_pkg;

	localparam int IMG_W = 6;
	localparam int IMG_H = 6;
	localparam int KSIZE = 3;
	localparam int TAPS = KSIZE * KSIZE;
	localparam int IN_CH = 2;
	localparam int OUT_CH = 4;

	localparam int DATA_W = 8;
	localparam int PROD_W = 2 * DATA_W;
	localparam int BIAS_W = 16;
	// 18 products plus the bias, signed
	localparam int ACC_W = 21;
	localparam int TAG_W = 3;

	localparam int OUT_W = IMG_W - 2;
	localparam int OUT_H = IMG_H - 2;
	localparam int WEIGHT_WORDS = OUT_CH * TAPS;
	localparam int FIFO_DEPTH = 4;
	// delay between the end of one window row and the head of the next
	localparam int LINE_LEN = IMG_W - KSIZE;

	typedef logic signed [DATA_W-1:0] data_t;
	typedef data_t [IN_CH-1:0] pixel_t;
	typedef logic signed [PROD_W-1:0] prod_t;
	typedef logic signed [BIAS_W-1:0] bias_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [TAG_W-1:0] tag_t;

	typedef acc_t [OUT_CH-1:0] result_t;
	typedef pixel_t [OUT_CH-1:0][TAPS-1:0] weight_bank_t;
	typedef bias_t [OUT_CH-1:0] bias_bank_t;

	// tap index is window row * 3 + window column
	typedef struct packed {
		pixel_t [TAPS-1:0] taps;
		tag_t              row;
		tag_t              col;
	} window_t;

	typedef logic [$clog2(WEIGHT_WORDS + 1)-1:0] wcnt_t;
	typedef logic [$clog2(OUT_CH + 1)-1:0] bcnt_t;
	typedef logic [$clog2(FIFO_DEPTH + 1)-1:0] slot_t;
	typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;

	localparam tag_t WIN_START = tag_t'(KSIZE - 1);

endpackage

// ==== hdl/window_if.sv ====
`timescale 1ns/1ps

// window stream with credit return
interface window_if;

	logic              valid;
	conv_pkg::window_t window;
	// one pulse per popped entry
	logic              credit;

	modport producer (
		output valid,
		output window,
		input  credit
	);

	modport buffer (
		input  valid,
		input  window,
		output credit
	);

endinterface

// ==== hdl/coef_loader.sv ====
`timescale 1ns/1ps

module coef_loader (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   weight_valid,
	input  conv_pkg::pixel_t       weight_data,
	input  logic                   bias_valid,
	input  conv_pkg::bias_t        bias_data,
	output conv_pkg::weight_bank_t weights,
	output conv_pkg::bias_bank_t   biases,
	output logic                   loaded
);

	conv_pkg::pixel_t [conv_pkg::WEIGHT_WORDS-1:0] w_chain;
	conv_pkg::bias_t [conv_pkg::OUT_CH-1:0]        b_chain;

	conv_pkg::wcnt_t w_count;
	conv_pkg::wcnt_t w_count_nxt;
	conv_pkg::bcnt_t b_count;
	conv_pkg::bcnt_t b_count_nxt;
	logic            w_full;
	logic            b_full;

	// chain index is channel * TAPS + tap
	assign weights = w_chain;
	assign biases  = b_chain;

	// newest word at the tail, oldest ends at index 0
	always_ff @(posedge clk)
	begin
		if (weight_valid)
			w_chain <= {weight_data, w_chain[conv_pkg::WEIGHT_WORDS-1:1]};
		if (bias_valid)
			b_chain <= {bias_data, b_chain[conv_pkg::OUT_CH-1:1]};
	end

	assign w_full = (w_count == conv_pkg::wcnt_t'(conv_pkg::WEIGHT_WORDS));
	assign b_full = (b_count == conv_pkg::bcnt_t'(conv_pkg::OUT_CH));

	// a word after a full set starts the set over
	always_comb
	begin
		w_count_nxt = w_count;
		b_count_nxt = b_count;
		if (weight_valid)
			w_count_nxt = w_full ? conv_pkg::wcnt_t'(1) : w_count + 1'b1;
		if (bias_valid)
			b_count_nxt = b_full ? conv_pkg::bcnt_t'(1) : b_count + 1'b1;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			w_count <= '0;
			b_count <= '0;
			loaded  <= 1'b0;
		end
		else
		begin
			w_count <= w_count_nxt;
			b_count <= b_count_nxt;
			loaded  <= (w_count_nxt == conv_pkg::wcnt_t'(conv_pkg::WEIGHT_WORDS)) &&
				(b_count_nxt == conv_pkg::bcnt_t'(conv_pkg::OUT_CH));
		end
	end

endmodule

// ==== hdl/line_window.sv ====
`timescale 1ns/1ps

module line_window (
	input  logic             clk,
	input  logic             rst,
	input  logic             pixel_valid,
	input  conv_pkg::pixel_t pixel_data,
	output logic             pixel_ready,
	input  logic             loaded,
	window_if.producer       win
);

	// win_r[i][j] holds window row i, column j
	conv_pkg::pixel_t [conv_pkg::KSIZE-1:0][conv_pkg::KSIZE-1:0] win_r;
	conv_pkg::pixel_t [conv_pkg::LINE_LEN-1:0]                   line1;
	conv_pkg::pixel_t [conv_pkg::LINE_LEN-1:0]                   line2;

	conv_pkg::tag_t    row;
	conv_pkg::tag_t    col;
	conv_pkg::tag_t    tag_row;
	conv_pkg::tag_t    tag_col;
	conv_pkg::slot_t   credits;
	conv_pkg::window_t win_word;
	logic              accept;
	logic              emit;

	assign pixel_ready = loaded && (credits != '0);
	assign accept      = pixel_valid && pixel_ready;
	assign emit        = accept && (row >= conv_pkg::WIN_START) && (col >= conv_pkg::WIN_START);

	// shift chain: pixel -> bottom row -> line1 -> middle row -> line2 -> top row
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			for (int i = 0; i < conv_pkg::KSIZE; i++)
			begin
				for (int j = 0; j < conv_pkg::KSIZE - 1; j++)
					win_r[i][j] <= win_r[i][j+1];
			end
			win_r[2][conv_pkg::KSIZE-1] <= pixel_data;
			line1 <= {win_r[2][0], line1[conv_pkg::LINE_LEN-1:1]};
			win_r[1][conv_pkg::KSIZE-1] <= line1[0];
			line2 <= {win_r[1][0], line2[conv_pkg::LINE_LEN-1:1]};
			win_r[0][conv_pkg::KSIZE-1] <= line2[0];
			tag_row <= row - conv_pkg::WIN_START;
			tag_col <= col - conv_pkg::WIN_START;
		end
	end

	always_comb
	begin
		win_word.taps = win_r;
		win_word.row  = tag_row;
		win_word.col  = tag_col;
	end

	assign win.window = win_word;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			row       <= '0;
			col       <= '0;
			credits   <= conv_pkg::slot_t'(conv_pkg::FIFO_DEPTH);
			win.valid <= 1'b0;
		end
		else
		begin
			win.valid <= emit;
			// raster position of the next pixel
			if (accept)
			begin
				if (col == conv_pkg::tag_t'(conv_pkg::IMG_W - 1))
				begin
					col <= '0;
					if (row == conv_pkg::tag_t'(conv_pkg::IMG_H - 1))
						row <= '0;
					else
						row <= row + 1'b1;
				end
				else
				begin
					col <= col + 1'b1;
				end
			end
			// credit is taken when the window is committed
			case ({win.credit, emit})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

// ==== hdl/window_fifo.sv ====
`timescale 1ns/1ps

module window_fifo #(
	parameter type payload_t = conv_pkg::window_t
) (
	input  logic     clk,
	input  logic     rst,
	window_if.buffer win,
	output logic     fifo_valid,
	input  logic     fifo_pop,
	output payload_t fifo_data
);

	payload_t        mem [conv_pkg::FIFO_DEPTH];
	conv_pkg::ptr_t  wr_ptr;
	conv_pkg::ptr_t  rd_ptr;
	conv_pkg::slot_t count;
	logic            pop;

	function automatic conv_pkg::ptr_t next_ptr(conv_pkg::ptr_t p);
		return (p == conv_pkg::ptr_t'(conv_pkg::FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// head entry is visible without a read cycle
	assign fifo_valid = (count != '0);
	assign fifo_data  = mem[rd_ptr];
	assign pop        = fifo_pop && fifo_valid;

	// no full check, the producer only writes against credit
	always_ff @(posedge clk)
	begin
		if (win.valid)
			mem[wr_ptr] <= win.window;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			win.credit <= 1'b0;
		end
		else
		begin
			if (win.valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({win.valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			win.credit <= pop;
		end
	end

endmodule

// ==== hdl/conv_engine.sv ====
`timescale 1ns/1ps

module conv_engine (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   fifo_valid,
	output logic                   fifo_pop,
	input  conv_pkg::window_t      fifo_data,
	input  conv_pkg::weight_bank_t weights,
	input  conv_pkg::bias_bank_t   biases,
	output logic                   out_valid,
	input  logic                   out_ready,
	output conv_pkg::result_t      out_data,
	output conv_pkg::tag_t         out_row,
	output conv_pkg::tag_t         out_col,
	output logic                   frame_done
);

	conv_pkg::prod_t   s1_prod [conv_pkg::OUT_CH][conv_pkg::TAPS][conv_pkg::IN_CH];
	logic              s1_valid;
	conv_pkg::tag_t    s1_row;
	conv_pkg::tag_t    s1_col;
	conv_pkg::acc_t    tap_sum [conv_pkg::OUT_CH][conv_pkg::TAPS];
	conv_pkg::result_t sum;
	logic              stall;

	// a held output freezes the whole pipe
	assign stall    = out_valid && !out_ready;
	assign fifo_pop = fifo_valid && !stall;

	assign frame_done = out_valid && out_ready &&
		(out_row == conv_pkg::tag_t'(conv_pkg::OUT_H - 1)) &&
		(out_col == conv_pkg::tag_t'(conv_pkg::OUT_W - 1));

	// stage 1: every product of every output channel
	always_ff @(posedge clk)
	begin
		if (fifo_pop)
		begin
			for (int o = 0; o < conv_pkg::OUT_CH; o++)
			begin
				for (int t = 0; t < conv_pkg::TAPS; t++)
				begin
					for (int c = 0; c < conv_pkg::IN_CH; c++)
						s1_prod[o][t][c] <= fifo_data.taps[t][c] * weights[o][t][c];
				end
			end
			s1_row <= fifo_data.row;
			s1_col <= fifo_data.col;
		end
	end

	// per-tap partials over input channels, then taps and bias
	always_comb
	begin
		for (int o = 0; o < conv_pkg::OUT_CH; o++)
		begin
			sum[o] = conv_pkg::acc_t'(biases[o]);
			for (int t = 0; t < conv_pkg::TAPS; t++)
			begin
				tap_sum[o][t] = '0;
				for (int c = 0; c < conv_pkg::IN_CH; c++)
					tap_sum[o][t] = tap_sum[o][t] + conv_pkg::acc_t'(s1_prod[o][t][c]);
				sum[o] = sum[o] + tap_sum[o][t];
			end
		end
	end

	// stage 2 result and tags
	always_ff @(posedge clk)
	begin
		if (!stall && s1_valid)
		begin
			out_data <= sum;
			out_row  <= s1_row;
			out_col  <= s1_col;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end
		else if (!stall)
		begin
			s1_valid  <= fifo_pop;
			out_valid <= s1_valid;
		end
	end

endmodule

// ==== hdl/conv_layer.sv ====
`timescale 1ns/1ps

module conv_layer (
	input  logic              clk,
	input  logic              rst,
	input  logic              weight_valid,
	input  conv_pkg::pixel_t  weight_data,
	input  logic              bias_valid,
	input  conv_pkg::bias_t   bias_data,
	input  logic              pixel_valid,
	input  conv_pkg::pixel_t  pixel_data,
	output logic              pixel_ready,
	output logic              out_valid,
	input  logic              out_ready,
	output conv_pkg::result_t out_data,
	output conv_pkg::tag_t    out_row,
	output conv_pkg::tag_t    out_col,
	output logic              frame_done
);

	conv_pkg::weight_bank_t weights;
	conv_pkg::bias_bank_t   biases;
	logic                   loaded;
	logic                   fifo_valid;
	logic                   fifo_pop;
	conv_pkg::window_t      fifo_data;

	window_if win_bus ();

	coef_loader u_coef (
		.clk          (clk),
		.rst          (rst),
		.weight_valid (weight_valid),
		.weight_data  (weight_data),
		.bias_valid   (bias_valid),
		.bias_data    (bias_data),
		.weights      (weights),
		.biases       (biases),
		.loaded       (loaded)
	);

	line_window u_window (
		.clk         (clk),
		.rst         (rst),
		.pixel_valid (pixel_valid),
		.pixel_data  (pixel_data),
		.pixel_ready (pixel_ready),
		.loaded      (loaded),
		.win         (win_bus.producer)
	);

	window_fifo #(
		.payload_t (conv_pkg::window_t)
	) u_fifo (
		.clk        (clk),
		.rst        (rst),
		.win        (win_bus.buffer),
		.fifo_valid (fifo_valid),
		.fifo_pop   (fifo_pop),
		.fifo_data  (fifo_data)
	);

	conv_engine u_engine (
		.clk        (clk),
		.rst        (rst),
		.fifo_valid (fifo_valid),
		.fifo_pop   (fifo_pop),
		.fifo_data  (fifo_data),
		.weights    (weights),
		.biases     (biases),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_data   (out_data),
		.out_row    (out_row),
		.out_col    (out_col),
		.frame_done (frame_done)
	);

endmodule

// ==== test/tb_conv.sv ====
`timescale 1ns/1ps

module tb_conv;

	localparam int TIMEOUT_CYCLES = 300;
	localparam int FRAME_OUTPUTS = conv_pkg::OUT_W * conv_pkg::OUT_H;

	logic              clk;
	logic              rst;
	logic              weight_valid;
	conv_pkg::pixel_t  weight_data;
	logic              bias_valid;
	conv_pkg::bias_t   bias_data;
	logic              pixel_valid;
	conv_pkg::pixel_t  pixel_data;
	logic              pixel_ready;
	logic              out_valid;
	logic              out_ready;
	conv_pkg::result_t out_data;
	conv_pkg::tag_t    out_row;
	conv_pkg::tag_t    out_col;
	logic              frame_done;

	// model copies of the frame and the coefficients
	conv_pkg::pixel_t img [conv_pkg::IMG_H][conv_pkg::IMG_W];
	conv_pkg::pixel_t weight_ref [conv_pkg::OUT_CH][conv_pkg::TAPS];
	conv_pkg::bias_t  bias_ref [conv_pkg::OUT_CH];

	logic [31:0] rng_state;
	logic        outputs_done;
	logic        saw_ready_drop;

	conv_layer dut (
		.clk          (clk),
		.rst          (rst),
		.weight_valid (weight_valid),
		.weight_data  (weight_data),
		.bias_valid   (bias_valid),
		.bias_data    (bias_data),
		.pixel_valid  (pixel_valid),
		.pixel_data   (pixel_data),
		.pixel_ready  (pixel_ready),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_data     (out_data),
		.out_row      (out_row),
		.out_col      (out_col),
		.frame_done   (frame_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic end_with_failure();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare_result(string test, conv_pkg::result_t exp, conv_pkg::result_t act);
		if (exp !== act)
		begin
			$display("FAIL %s: out_data expected %h, actual %h", test, exp, act);
			end_with_failure();
		end
	endtask

	task automatic compare_tag(string test, string what, conv_pkg::tag_t exp,
		conv_pkg::tag_t act);
		if (exp !== act)
		begin
			$display("FAIL %s: %s expected %0d, actual %0d", test, what, exp, act);
			end_with_failure();
		end
	endtask

	task automatic compare_flag(string test, string what, logic exp, logic act);
		if (exp !== act)
		begin
			$display("FAIL %s: %s expected %b, actual %b", test, what, exp, act);
			end_with_failure();
		end
	endtask

	task automatic report_stall(string what);
		$display("TIMEOUT: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
		end_with_failure();
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// bias plus every tap times weight, over both input channels
	function automatic conv_pkg::result_t expected_result(int orow, int ocol);
		conv_pkg::result_t res;
		int                acc;
		for (int o = 0; o < conv_pkg::OUT_CH; o++)
		begin
			acc = int'(bias_ref[o]);
			for (int i = 0; i < conv_pkg::KSIZE; i++)
			begin
				for (int j = 0; j < conv_pkg::KSIZE; j++)
				begin
					for (int ch = 0; ch < conv_pkg::IN_CH; ch++)
						acc += int'(img[orow + i][ocol + j][ch]) *
							int'(weight_ref[o][i * conv_pkg::KSIZE + j][ch]);
				end
			end
			res[o] = conv_pkg::acc_t'(acc);
		end
		return res;
	endfunction

	task automatic step_clock();
		@(posedge clk);
		#2;
	endtask

	task automatic fill_identity_coefs();
		for (int o = 0; o < conv_pkg::OUT_CH; o++)
		begin
			for (int t = 0; t < conv_pkg::TAPS; t++)
				weight_ref[o][t] = '0;
			// center tap, input channel 0 only
			weight_ref[o][conv_pkg::TAPS / 2][0] = 8'sd1;
			bias_ref[o] = conv_pkg::bias_t'(7 * o - 5);
		end
	endtask

	task automatic fill_random_coefs();
		logic [31:0] r;
		for (int o = 0; o < conv_pkg::OUT_CH; o++)
		begin
			for (int t = 0; t < conv_pkg::TAPS; t++)
			begin
				r = next_random();
				weight_ref[o][t] = r[15:0];
			end
			r = next_random();
			bias_ref[o] = r[15:0];
		end
	endtask

	task automatic fill_random_image();
		logic [31:0] r;
		for (int y = 0; y < conv_pkg::IMG_H; y++)
		begin
			for (int x = 0; x < conv_pkg::IMG_W; x++)
			begin
				r = next_random();
				img[y][x] = r[15:0];
			end
		end
	endtask

	// weights channel by channel, then biases
	task automatic load_coefficients(string test, bit check_ready);
		for (int o = 0; o < conv_pkg::OUT_CH; o++)
		begin
			for (int t = 0; t < conv_pkg::TAPS; t++)
			begin
				weight_valid = 1'b1;
				weight_data  = weight_ref[o][t];
				if (check_ready)
				begin
					@(negedge clk);
					compare_flag(test, "pixel_ready while loading", 1'b0, pixel_ready);
				end
				step_clock();
			end
		end
		weight_valid = 1'b0;
		for (int o = 0; o < conv_pkg::OUT_CH; o++)
		begin
			bias_valid = 1'b1;
			bias_data  = bias_ref[o];
			if (check_ready)
			begin
				@(negedge clk);
				compare_flag(test, "pixel_ready while loading", 1'b0, pixel_ready);
			end
			step_clock();
		end
		bias_valid = 1'b0;
	endtask

	task automatic wait_pixel_ready(string what);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!pixel_ready)
		begin
			waited++;
			if (waited > TIMEOUT_CYCLES)
				report_stall(what);
			@(negedge clk);
		end
	endtask

	task automatic send_pixel(conv_pkg::pixel_t p);
		pixel_valid = 1'b1;
		pixel_data  = p;
		wait_pixel_ready("pixel acceptance");
		step_clock();
	endtask

	task automatic feed_frame();
		for (int y = 0; y < conv_pkg::IMG_H; y++)
		begin
			for (int x = 0; x < conv_pkg::IMG_W; x++)
				send_pixel(img[y][x]);
		end
		pixel_valid = 1'b0;
	endtask

	task automatic drive_ready(bit random_ready);
		int          cycles;
		logic [31:0] r;
		cycles = 0;
		out_ready = !random_ready;
		while (!outputs_done)
		begin
			cycles++;
			if (cycles > 20 * TIMEOUT_CYCLES)
				report_stall("end of output collection");
			step_clock();
			if (random_ready)
			begin
				r = next_random();
				// hold a long stall first so the FIFO fills up
				out_ready = (cycles > 60) && (r[1:0] != 2'b00);
			end
		end
		out_ready = 1'b1;
	endtask

	task automatic collect_outputs(string test);
		int                idx;
		int                idle;
		int                exp_row;
		int                exp_col;
		logic              stall_prev;
		conv_pkg::result_t held_data;
		conv_pkg::tag_t    held_row;
		conv_pkg::tag_t    held_col;
		idx = 0;
		idle = 0;
		stall_prev = 1'b0;
		while (idx < FRAME_OUTPUTS)
		begin
			@(negedge clk);
			if (stall_prev)
			begin
				compare_flag(test, "out_valid while stalled", 1'b1, out_valid);
				compare_result(test, held_data, out_data);
				compare_tag(test, "held out_row", held_row, out_row);
				compare_tag(test, "held out_col", held_col, out_col);
			end
			if (out_valid && out_ready)
			begin
				exp_row = idx / conv_pkg::OUT_W;
				exp_col = idx % conv_pkg::OUT_W;
				compare_tag(test, "out_row", conv_pkg::tag_t'(exp_row), out_row);
				compare_tag(test, "out_col", conv_pkg::tag_t'(exp_col), out_col);
				compare_result(test, expected_result(exp_row, exp_col), out_data);
				compare_flag(test, "frame_done", idx == FRAME_OUTPUTS - 1, frame_done);
				idx++;
				idle = 0;
			end
			else
			begin
				compare_flag(test, "frame_done without output", 1'b0, frame_done);
				idle++;
				if (idle > TIMEOUT_CYCLES)
					report_stall("next output");
			end
			if (out_valid && !out_ready && !pixel_ready)
				saw_ready_drop = 1'b1;
			stall_prev = out_valid && !out_ready;
			held_data  = out_data;
			held_row   = out_row;
			held_col   = out_col;
		end
		outputs_done = 1'b1;
	endtask

	task automatic run_frame(string test, bit random_ready);
		outputs_done   = 1'b0;
		saw_ready_drop = 1'b0;
		fill_random_image();
		fork
			feed_frame();
			collect_outputs(test);
			drive_ready(random_ready);
		join
		if (random_ready && !saw_ready_drop)
		begin
			$display("pixel_ready never dropped under back-pressure in %s", test);
			end_with_failure();
		end
		// no extra result may follow the last one
		repeat (8)
		begin
			@(negedge clk);
			compare_flag(test, "out_valid after frame", 1'b0, out_valid);
			compare_flag(test, "frame_done after frame", 1'b0, frame_done);
		end
		step_clock();
	endtask

	task automatic test_reset_and_load();
		@(negedge clk);
		compare_flag("reset_and_load", "out_valid after reset", 1'b0, out_valid);
		compare_flag("reset_and_load", "frame_done after reset", 1'b0, frame_done);
		compare_flag("reset_and_load", "pixel_ready after reset", 1'b0, pixel_ready);
		step_clock();
		fill_identity_coefs();
		load_coefficients("reset_and_load", 1'b1);
		wait_pixel_ready("pixel_ready after loading");
		step_clock();
	endtask

	task automatic test_identity_frame();
		run_frame("identity_frame", 1'b0);
	endtask

	task automatic test_random_frame();
		fill_random_coefs();
		load_coefficients("random_frame", 1'b0);
		run_frame("random_frame", 1'b0);
	endtask

	task automatic test_backpressure();
		run_frame("backpressure", 1'b1);
	endtask

	task automatic test_reload();
		run_frame("reload_first", 1'b0);
		fill_random_coefs();
		load_coefficients("reload", 1'b0);
		run_frame("reload_second", 1'b0);
	endtask

	initial
	begin
		rng_state      = 32'd28001;
		rst            = 1'b1;
		weight_valid   = 1'b0;
		weight_data    = '0;
		bias_valid     = 1'b0;
		bias_data      = '0;
		pixel_valid    = 1'b0;
		pixel_data     = '0;
		out_ready      = 1'b0;
		outputs_done   = 1'b0;
		saw_ready_drop = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		test_reset_and_load();
		test_identity_frame();
		test_random_frame();
		test_backpressure();
		test_reload();
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== flist.f ====
hdl/conv_pkg.sv
hdl/window_if.sv
hdl/coef_loader.sv
hdl/line_window.sv
hdl/window_fifo.sv
hdl/conv_engine.sv
hdl/conv_layer.sv
test/tb_conv.sv

// ==== run.sh ====
#!/bin/sh
# build and run the conv_layer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_conv -Mdir obj_dir -o sim_conv \
	-f flist.f > build.log 2>&1 \
	&& ./obj_dir/sim_conv > sim.log 2>&1 \
	|| echo "build or simulation returned an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "^>>> PASS$" sim.log 2>/dev/null && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
